/* sim.f */
rtl/shell_rom_pkg.sv
rtl/shell_input_pkg.sv
rtl/rom_port_if.sv
rtl/rom_access_ctrl.sv
rtl/rom_store.sv
rtl/key_decoder.sv
rtl/control_mapper.sv
rtl/arcade_shell_top.sv
tests/tb_arcade_shell.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_arcade_shell
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^Test OK$$' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_arcade_shell.sv */
// Arcade shell testbench
// downloads an LCG image into the shell, then checks boot reset,
// main and sound CPU fetches, port contention, key decoding and
// the joystick and rotation mapping against a reference model
`default_nettype none

module tb_arcade_shell;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int IMAGE_BYTES = 6144;
	localparam int SND_BASE = 4096;
	localparam int DL_SPACING = 8;
	localparam int N_TESTS = 6;
	localparam int N_FETCH = 64;
	localparam int N_JOY = 48;
	// download time plus a budget per test, doubled
	localparam int WATCHDOG_CYCLES = 2 * (IMAGE_BYTES * DL_SPACING + N_TESTS * N_FETCH * 16);

	logic clk_sys;
	logic arst_n;
	logic dl_active;
	logic dl_wr;
	logic [12:0] dl_addr;
	logic [7:0] dl_data;
	logic cpu_rom_rd;
	logic [11:0] cpu_rom_addr;
	logic snd_rom_rd;
	logic [10:0] snd_rom_addr;
	logic reset_req;
	logic key_strobe;
	logic key_pressed;
	logic [7:0] key_code;
	logic [7:0] joystick_0;
	logic [7:0] joystick_1;
	logic rotate;
	logic [7:0] cpu_rom_data;
	logic [7:0] snd_rom_data;
	logic core_reset;
	logic ctrl_left;
	logic ctrl_right;
	logic ctrl_fire;
	logic ctrl_bomb;
	logic ctrl_coin;
	logic ctrl_start1;
	logic ctrl_start2;

	// reference image and key model, buttons in scan table order
	logic [7:0] image [IMAGE_BYTES];
	logic [7:0] key_table [9];
	logic [8:0] btn_model;
	logic [31:0] lcg_state;
	logic booted;
	logic reset_req_q;
	int err_count;
	int tests_run;
	int tests_failed;

	arcade_shell_top arcade_shell_top_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		reset_req_q <= reset_req;
	end

	// ====================
	// concurrent checks
	// ====================
	a_dl_holds_reset: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dl_active |=> core_reset)
	else begin
		err_count++;
		$display("[ERROR] core_reset got %h exp %h during download", $sampled(core_reset), 1'b1);
	end

	// once booted, core_reset is reset_req one cycle late
	a_reset_follows: assert property (@(posedge clk_sys) disable iff (!arst_n || !booted)
		core_reset == reset_req_q)
	else begin
		err_count++;
		$display("[ERROR] core_reset got %h exp %h", $sampled(core_reset), $sampled(reset_req_q));
	end

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [6:0] expected_ctrl(input logic [8:0] btn, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot);
		logic [7:0] j;
		logic left;
		logic right;
		j = j0 | j1;
		// unrotated, down and up steer left and right
		left = rot ? (btn[2] | j[1]) : (btn[1] | j[2]);
		right = rot ? (btn[3] | j[0]) : (btn[0] | j[3]);
		return {left, right, btn[4] | j[4], btn[5] | j[5], btn[6], btn[7], btn[8]};
	endfunction

	task automatic check_byte(input string name, input int addr, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got == exp) else begin
			err_count++;
			$display("[ERROR] %s got %h exp %h at addr %h", name, got, exp, addr);
		end
	endtask

	task automatic check_ctrl(input string what);
		logic [6:0] got;
		logic [6:0] exp;
		@(negedge clk_sys);
		got = {ctrl_left, ctrl_right, ctrl_fire, ctrl_bomb, ctrl_coin, ctrl_start1, ctrl_start2};
		exp = expected_ctrl(btn_model, joystick_0, joystick_1, rotate);
		assert (got == exp) else begin
			err_count++;
			$display("[ERROR] ctrl {left,right,fire,bomb,coin,start1,start2} got %h exp %h (%s)",
				got, exp, what);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", tests_run, name, err_count - errs_before);
		end
	endtask

	task automatic press_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		key_strobe <= 1'b1;
		key_pressed <= pressed;
		key_code <= code;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
	endtask

	task automatic apply_key(input int idx, input logic pressed);
		press_key(key_table[idx], pressed);
		btn_model[idx] = pressed;
	endtask

	task automatic download_image();
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int i = 0; i < IMAGE_BYTES; i++) begin
			@(posedge clk_sys);
			dl_wr <= 1'b1;
			dl_addr <= 13'(i);
			dl_data <= image[i];
			@(posedge clk_sys);
			dl_wr <= 1'b0;
			repeat (DL_SPACING - 2) @(posedge clk_sys);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	// ====================
	// tests
	// ====================
	task automatic boot_test();
		int errs;
		logic [31:0] r;
		errs = err_count;
		check_ctrl("after reset");
		assert (core_reset == 1'b1) else begin
			err_count++;
			$display("[ERROR] core_reset got %h exp %h after reset", core_reset, 1'b1);
		end
		download_image();
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		assert (core_reset == 1'b0) else begin
			err_count++;
			$display("[ERROR] core_reset got %h exp %h after download", core_reset, 1'b0);
		end
		booted = 1'b1;
		for (int n = 0; n < 16; n++) begin
			r = lcg_next();
			@(posedge clk_sys);
			reset_req <= r[20];
		end
		@(posedge clk_sys);
		reset_req <= 1'b0;
		repeat (2) @(posedge clk_sys);
		finish_test("boot reset", errs);
	endtask

	task automatic cpu_fetch_test();
		int errs;
		int addr;
		logic [31:0] r;
		errs = err_count;
		for (int n = 0; n < N_FETCH; n++) begin
			r = lcg_next();
			addr = int'(r[27:16]);
			@(posedge clk_sys);
			cpu_rom_rd <= 1'b1;
			cpu_rom_addr <= 12'(addr);
			repeat (4) @(posedge clk_sys);
			@(negedge clk_sys);
			check_byte("cpu_rom_data", addr, cpu_rom_data, image[addr]);
		end
		finish_test("cpu fetch", errs);
	endtask

	task automatic snd_fetch_test();
		int errs;
		int addr;
		logic [31:0] r;
		errs = err_count;
		for (int n = 0; n < N_FETCH; n++) begin
			r = lcg_next();
			addr = int'(r[26:16]);
			@(posedge clk_sys);
			snd_rom_rd <= 1'b1;
			snd_rom_addr <= 11'(addr);
			repeat (4) @(posedge clk_sys);
			@(negedge clk_sys);
			check_byte("snd_rom_data", addr, snd_rom_data, image[SND_BASE + addr]);
		end
		finish_test("sound fetch", errs);
	endtask

	task automatic contention_test();
		int errs;
		int ca;
		int sa;
		logic [31:0] r;
		errs = err_count;
		for (int n = 0; n < N_FETCH / 2; n++) begin
			r = lcg_next();
			ca = int'(r[31:20]);
			sa = int'(r[18:8]);
			@(posedge clk_sys);
			cpu_rom_addr <= 12'(ca);
			snd_rom_addr <= 11'(sa);
			repeat (7) @(posedge clk_sys);
			@(negedge clk_sys);
			check_byte("cpu_rom_data", ca, cpu_rom_data, image[ca]);
			check_byte("snd_rom_data", sa, snd_rom_data, image[SND_BASE + sa]);
			// other byte of the same word, served from the held word
			@(posedge clk_sys);
			cpu_rom_addr <= 12'(ca ^ 1);
			snd_rom_addr <= 11'(sa ^ 1);
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_byte("cpu_rom_data", ca ^ 1, cpu_rom_data, image[ca ^ 1]);
			check_byte("snd_rom_data", sa ^ 1, snd_rom_data, image[SND_BASE + (sa ^ 1)]);
		end
		finish_test("contention", errs);
	endtask

	task automatic key_test();
		int errs;
		errs = err_count;
		for (int i = 0; i < 9; i++) begin
			@(posedge clk_sys);
			rotate <= (i == 2 || i == 3);
			apply_key(i, 1'b1);
			check_ctrl("key press");
			apply_key(i, 1'b0);
			check_ctrl("key release");
		end
		press_key(8'h1C, 1'b1);
		check_ctrl("unknown code");
		@(posedge clk_sys);
		rotate <= ~rotate;
		check_ctrl("unknown code, other rotation");
		finish_test("keys", errs);
	endtask

	task automatic joystick_test();
		int errs;
		logic [31:0] r;
		logic [31:0] s;
		errs = err_count;
		for (int n = 0; n < N_JOY; n++) begin
			r = lcg_next();
			s = lcg_next();
			@(posedge clk_sys);
			// sparse sticks so single sources show up
			joystick_0 <= r[7:0] & r[15:8];
			joystick_1 <= r[23:16] & r[31:24];
			rotate <= s[24];
			apply_key(int'(s[23:20]) % 9, s[19]);
			check_ctrl("joystick");
		end
		@(posedge clk_sys);
		joystick_0 <= '0;
		joystick_1 <= '0;
		finish_test("joysticks and rotation", errs);
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		lcg_state = 32'h8171;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		booted = 1'b0;
		btn_model = '0;
		key_table = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h29, 8'h11, 8'h76, 8'h05, 8'h06};
		arst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_rom_rd = 1'b0;
		cpu_rom_addr = '0;
		snd_rom_rd = 1'b0;
		snd_rom_addr = '0;
		reset_req = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b0;
		for (int i = 0; i < IMAGE_BYTES; i++) begin
			image[i] = 8'(lcg_next() >> 16);
		end
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
		boot_test();
		cpu_fetch_test();
		snd_fetch_test();
		@(posedge clk_sys);
		cpu_rom_rd <= 1'b1;
		snd_rom_rd <= 1'b1;
		contention_test();
		key_test();
		joystick_test();
		$display("tests %0d, passed %0d, failed %0d, check errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/arcade_shell_top.sv */
// Arcade board shell
// loads the ROM image from the host download into the word store,
// serves main and sound CPU fetches, gates the core reset on a full
// image, and maps keyboard and joysticks onto cabinet controls
`default_nettype none

module arcade_shell_top (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  shell_rom_pkg::dl_addr_t    dl_addr,
	input  shell_rom_pkg::byte_t       dl_data,
	input  logic                       cpu_rom_rd,
	input  shell_rom_pkg::cpu_addr_t   cpu_rom_addr,
	input  logic                       snd_rom_rd,
	input  shell_rom_pkg::snd_addr_t   snd_rom_addr,
	input  logic                       reset_req,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  shell_input_pkg::key_code_t key_code,
	input  shell_input_pkg::joy_t      joystick_0,
	input  shell_input_pkg::joy_t      joystick_1,
	input  logic                       rotate,
	output shell_rom_pkg::byte_t       cpu_rom_data,
	output shell_rom_pkg::byte_t       snd_rom_data,
	output logic                       core_reset,
	output logic                       ctrl_left,
	output logic                       ctrl_right,
	output logic                       ctrl_fire,
	output logic                       ctrl_bomb,
	output logic                       ctrl_coin,
	output logic                       ctrl_start1,
	output logic                       ctrl_start2
);

	shell_input_pkg::buttons_t buttons;

	// port 1 for main CPU and download, port 2 for sound
	rom_port_if cpu_port ();
	rom_port_if snd_port ();

	rom_access_ctrl rom_access_ctrl_inst (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cpu_rom_rd   (cpu_rom_rd),
		.cpu_rom_addr (cpu_rom_addr),
		.cpu_rom_data (cpu_rom_data),
		.snd_rom_rd   (snd_rom_rd),
		.snd_rom_addr (snd_rom_addr),
		.snd_rom_data (snd_rom_data),
		.reset_req    (reset_req),
		.core_reset   (core_reset),
		.cpu_port     (cpu_port.requester),
		.snd_port     (snd_port.requester)
	);

	rom_store rom_store_inst (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.cpu_port (cpu_port.memory),
		.snd_port (snd_port.memory)
	);

	key_decoder key_decoder_inst (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons)
	);

	control_mapper control_mapper_inst (
		.buttons     (buttons),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.ctrl_left   (ctrl_left),
		.ctrl_right  (ctrl_right),
		.ctrl_fire   (ctrl_fire),
		.ctrl_bomb   (ctrl_bomb),
		.ctrl_coin   (ctrl_coin),
		.ctrl_start1 (ctrl_start1),
		.ctrl_start2 (ctrl_start2)
	);

endmodule

`default_nettype wire

/* rtl/control_mapper.sv */
// Control mapper
// ORs keyboard buttons with both joysticks into cabinet controls;
// without rotation the stick's down and up drive left and right
`default_nettype none

module control_mapper (
	input  shell_input_pkg::buttons_t buttons,
	input  shell_input_pkg::joy_t     joystick_0,
	input  shell_input_pkg::joy_t     joystick_1,
	input  logic                      rotate,
	output logic                      ctrl_left,
	output logic                      ctrl_right,
	output logic                      ctrl_fire,
	output logic                      ctrl_bomb,
	output logic                      ctrl_coin,
	output logic                      ctrl_start1,
	output logic                      ctrl_start2
);

	shell_input_pkg::joy_t joy_any;

	assign joy_any = joystick_0 | joystick_1;

	// rotated cabinet, screen turned a quarter
	assign ctrl_left = rotate
		? buttons.left | joy_any[shell_input_pkg::JOY_LEFT]
		: buttons.down | joy_any[shell_input_pkg::JOY_DOWN];
	assign ctrl_right = rotate
		? buttons.right | joy_any[shell_input_pkg::JOY_RIGHT]
		: buttons.up | joy_any[shell_input_pkg::JOY_UP];

	assign ctrl_fire = buttons.fire1 | joy_any[shell_input_pkg::JOY_FIRE];
	assign ctrl_bomb = buttons.fire2 | joy_any[shell_input_pkg::JOY_BOMB];
	assign ctrl_coin = buttons.coin;
	assign ctrl_start1 = buttons.start1;
	assign ctrl_start2 = buttons.start2;

endmodule

`default_nettype wire

/* rtl/key_decoder.sv */
// Keyboard decoder
// keeps one held level per cabinet button, updated from the scan
// code strobes; codes that name no button are ignored
`default_nettype none

module key_decoder (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  shell_input_pkg::key_code_t key_code,
	output shell_input_pkg::buttons_t  buttons
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;
		end else if (key_strobe) begin
			// make sets the level, break clears it
			case (key_code)
				shell_input_pkg::KEY_UP:     buttons.up <= key_pressed;
				shell_input_pkg::KEY_DOWN:   buttons.down <= key_pressed;
				shell_input_pkg::KEY_LEFT:   buttons.left <= key_pressed;
				shell_input_pkg::KEY_RIGHT:  buttons.right <= key_pressed;
				shell_input_pkg::KEY_FIRE1:  buttons.fire1 <= key_pressed;
				shell_input_pkg::KEY_FIRE2:  buttons.fire2 <= key_pressed;
				shell_input_pkg::KEY_COIN:   buttons.coin <= key_pressed;
				shell_input_pkg::KEY_START1: buttons.start1 <= key_pressed;
				shell_input_pkg::KEY_START2: buttons.start2 <= key_pressed;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/rom_store.sv */
// ROM word store
// two-port word memory with byte lane writes, answering toggle requests
// one at a time; port 1 wins a tie and every access acks a fixed
// number of cycles after it is taken
`default_nettype none

module rom_store (
	input  logic        clk_sys,
	input  logic        arst_n,
	rom_port_if.memory  cpu_port,
	rom_port_if.memory  snd_port
);

	shell_rom_pkg::word_t mem [shell_rom_pkg::STORE_WORDS];

	logic [$clog2(shell_rom_pkg::STORE_LATENCY + 1) - 1:0] busy_cnt;
	logic serve_snd;
	logic done;
	logic cpu_pend;
	logic snd_pend;

	shell_rom_pkg::word_addr_t acc_addr;
	logic [1:0] acc_be;
	logic acc_we;
	shell_rom_pkg::word_t acc_wdata;

	assign cpu_pend = cpu_port.req != cpu_port.ack;
	assign snd_pend = snd_port.req != snd_port.ack;
	assign done = busy_cnt == 1;

	// the requester holds its fields stable while pending
	assign acc_addr = serve_snd ? snd_port.addr : cpu_port.addr;
	assign acc_be = serve_snd ? snd_port.be : cpu_port.be;
	assign acc_we = serve_snd ? snd_port.we : cpu_port.we;
	assign acc_wdata = serve_snd ? snd_port.wdata : cpu_port.wdata;

	// ====================
	// arbiter
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			busy_cnt <= '0;
			serve_snd <= 1'b0;
			cpu_port.ack <= 1'b0;
			snd_port.ack <= 1'b0;
		end else if (busy_cnt == 0) begin
			if (cpu_pend) begin
				busy_cnt <= $bits(busy_cnt)'(shell_rom_pkg::STORE_LATENCY);
				serve_snd <= 1'b0;
			end else if (snd_pend) begin
				busy_cnt <= $bits(busy_cnt)'(shell_rom_pkg::STORE_LATENCY);
				serve_snd <= 1'b1;
			end
		end else begin
			busy_cnt <= busy_cnt - 1'b1;
			if (done) begin
				if (serve_snd) begin
					snd_port.ack <= snd_port.req;
				end else begin
					cpu_port.ack <= cpu_port.req;
				end
			end
		end
	end

	// ====================
	// array access
	// ====================
	always_ff @(posedge clk_sys) begin
		if (done) begin
			if (acc_we) begin
				if (acc_be[0]) begin
					mem[acc_addr][7:0] <= acc_wdata[7:0];
				end
				if (acc_be[1]) begin
					mem[acc_addr][15:8] <= acc_wdata[15:8];
				end
			end else if (serve_snd) begin
				snd_port.rdata <= mem[acc_addr];
			end else begin
				cpu_port.rdata <= mem[acc_addr];
			end
		end
	end

	// an ack lands STORE_LATENCY cycles after a pending request was taken
	a_cpu_ack_pending: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(cpu_port.ack) |-> $past(cpu_pend, shell_rom_pkg::STORE_LATENCY));
	a_snd_ack_pending: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(snd_port.ack) |-> $past(snd_pend, shell_rom_pkg::STORE_LATENCY));

endmodule

`default_nettype wire

/* rtl/rom_access_ctrl.sv */
// ROM access and boot controller
// turns host download bytes into lane writes on port 1, issues word
// fetches for the main and sound CPUs as toggle requests, picks the
// byte out of the fetched word, and holds the core in reset until a
// full image has been loaded
`default_nettype none

module rom_access_ctrl (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  shell_rom_pkg::dl_addr_t  dl_addr,
	input  shell_rom_pkg::byte_t     dl_data,
	input  logic                     cpu_rom_rd,
	input  shell_rom_pkg::cpu_addr_t cpu_rom_addr,
	output shell_rom_pkg::byte_t     cpu_rom_data,
	input  logic                     snd_rom_rd,
	input  shell_rom_pkg::snd_addr_t snd_rom_addr,
	output shell_rom_pkg::byte_t     snd_rom_data,
	input  logic                     reset_req,
	output logic                     core_reset,
	rom_port_if.requester            cpu_port,
	rom_port_if.requester            snd_port
);

	logic dl_wr_d;
	logic dl_rise;
	logic dl_issue;
	shell_rom_pkg::boot_state_t boot_state;

	shell_rom_pkg::cpu_word_t cpu_word;
	shell_rom_pkg::cpu_word_t cpu_last;
	logic cpu_vld;
	logic cpu_held;
	logic cpu_sel;
	logic cpu_pend;
	logic cpu_new;
	logic cpu_issue;

	shell_rom_pkg::snd_word_t snd_word;
	shell_rom_pkg::snd_word_t snd_last;
	logic snd_vld;
	logic snd_held;
	logic snd_sel;
	logic snd_pend;
	logic snd_new;
	logic snd_issue;

	assign dl_rise = dl_wr & ~dl_wr_d;
	assign dl_issue = dl_active & dl_rise;

	assign cpu_word = shell_rom_pkg::cpu_word_t'(cpu_rom_addr >> 1);
	assign snd_word = shell_rom_pkg::snd_word_t'(snd_rom_addr >> 1);
	assign cpu_pend = cpu_port.req != cpu_port.ack;
	assign snd_pend = snd_port.req != snd_port.ack;

	// a fetch only goes out for a word not already held
	assign cpu_new = ~dl_active & cpu_rom_rd & (~cpu_vld | (cpu_word != cpu_last));
	assign snd_new = ~dl_active & snd_rom_rd & (~snd_vld | (snd_word != snd_last));
	assign cpu_issue = (cpu_new | cpu_held) & ~cpu_pend;
	assign snd_issue = (snd_new | snd_held) & ~snd_pend;

	assign cpu_rom_data = cpu_sel ? cpu_port.rdata[15:8] : cpu_port.rdata[7:0];
	assign snd_rom_data = snd_sel ? snd_port.rdata[15:8] : snd_port.rdata[7:0];

	// ====================
	// request toggles
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_wr_d <= 1'b0;
			cpu_port.req <= 1'b0;
			snd_port.req <= 1'b0;
			cpu_vld <= 1'b0;
			snd_vld <= 1'b0;
			cpu_held <= 1'b0;
			snd_held <= 1'b0;
		end else begin
			dl_wr_d <= dl_wr;
			if (dl_active) begin
				// forget the trackers so the first fetch afterwards goes out
				cpu_vld <= 1'b0;
				snd_vld <= 1'b0;
				cpu_held <= 1'b0;
				snd_held <= 1'b0;
			end else begin
				if (cpu_new) begin
					cpu_vld <= 1'b1;
				end
				if (snd_new) begin
					snd_vld <= 1'b1;
				end
				// park the fetch until the port is free again
				if (cpu_new | cpu_held) begin
					cpu_held <= cpu_pend;
				end
				if (snd_new | snd_held) begin
					snd_held <= snd_pend;
				end
			end
			if (dl_issue | cpu_issue) begin
				cpu_port.req <= ~cpu_port.req;
			end
			if (snd_issue) begin
				snd_port.req <= ~snd_port.req;
			end
		end
	end

	// ====================
	// request payload
	// ====================
	always_ff @(posedge clk_sys) begin
		if (cpu_rom_rd) begin
			cpu_sel <= cpu_rom_addr[0];
		end
		if (snd_rom_rd) begin
			snd_sel <= snd_rom_addr[0];
		end
		if (cpu_new) begin
			cpu_last <= cpu_word;
		end
		if (snd_new) begin
			snd_last <= snd_word;
		end
		if (dl_issue) begin
			// one lane write, byte copied onto both halves
			cpu_port.addr <= shell_rom_pkg::word_addr_t'(dl_addr >> 1);
			cpu_port.be <= {dl_addr[0], ~dl_addr[0]};
			cpu_port.we <= 1'b1;
			cpu_port.wdata <= {dl_data, dl_data};
		end else if (cpu_issue) begin
			cpu_port.addr <= shell_rom_pkg::word_addr_t'(cpu_new ? cpu_word : cpu_last);
			cpu_port.be <= 2'b11;
			cpu_port.we <= 1'b0;
		end
		if (snd_issue) begin
			snd_port.addr <= shell_rom_pkg::SND_WORD_BASE
				+ shell_rom_pkg::word_addr_t'(snd_new ? snd_word : snd_last);
			snd_port.be <= 2'b11;
			snd_port.we <= 1'b0;
			snd_port.wdata <= '0;
		end
	end

	// ====================
	// boot FSM
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			boot_state <= shell_rom_pkg::wait_image;
			core_reset <= 1'b1;
		end else begin
			unique case (boot_state)
				shell_rom_pkg::wait_image,
				shell_rom_pkg::running: begin
					if (dl_active) begin
						boot_state <= shell_rom_pkg::loading;
					end
				end
				shell_rom_pkg::loading: begin
					if (!dl_active) begin
						boot_state <= shell_rom_pkg::running;
					end
				end
				default: boot_state <= shell_rom_pkg::wait_image;
			endcase
			core_reset <= (boot_state != shell_rom_pkg::running) | dl_active | reset_req;
		end
	end

	// the store copies req into ack, so req must stay put while pending
	a_cpu_req_idle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(cpu_port.req) |-> $past(cpu_port.req == cpu_port.ack));
	a_snd_req_idle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(snd_port.req) |-> $past(snd_port.req == snd_port.ack));

	// host spacing leaves room for a write behind a contended fetch
	a_dl_spacing: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dl_rise |=> !dl_rise [*7]);

endmodule

`default_nettype wire

/* rtl/rom_port_if.sv */
// ROM port interface
// one toggle-request memory port: a request is pending while req
// differs from ack, and the memory copies req into ack when done
`default_nettype none

interface rom_port_if;

	logic req;
	logic ack;
	shell_rom_pkg::word_addr_t addr;
	// byte lane enables, bit 0 is the low byte
	logic [1:0] be;
	logic we;
	shell_rom_pkg::word_t wdata;
	shell_rom_pkg::word_t rdata;

	modport requester (
		output req,
		output addr,
		output be,
		output we,
		output wdata,
		input  ack,
		input  rdata
	);

	modport memory (
		input  req,
		input  addr,
		input  be,
		input  we,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

`default_nettype wire

/* rtl/shell_input_pkg.sv */
// Input handling definitions
// keyboard scan codes, joystick bit positions and the button record
// shared by the key decoder and the control mapper
`default_nettype none

package shell_input_pkg;

	typedef logic [7:0] key_code_t;
	typedef logic [7:0] joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} buttons_t;

	// ====================
	// joystick bits
	// ====================
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT = 1;
	localparam int JOY_DOWN = 2;
	localparam int JOY_UP = 3;
	localparam int JOY_FIRE = 4;
	localparam int JOY_BOMB = 5;

	// ====================
	// scan codes
	// ====================
	localparam key_code_t KEY_UP = 8'h75;
	localparam key_code_t KEY_DOWN = 8'h72;
	localparam key_code_t KEY_LEFT = 8'h6B;
	localparam key_code_t KEY_RIGHT = 8'h74;
	// ESC
	localparam key_code_t KEY_COIN = 8'h76;
	// F1 and F2
	localparam key_code_t KEY_START1 = 8'h05;
	localparam key_code_t KEY_START2 = 8'h06;
	// space and alt
	localparam key_code_t KEY_FIRE1 = 8'h29;
	localparam key_code_t KEY_FIRE2 = 8'h11;

endpackage

`default_nettype wire

/* rtl/shell_rom_pkg.sv */
// ROM shell definitions
// widths of the download, CPU and store addresses, the stored word,
// and the layout of the two ROM regions inside the word store
`default_nettype none

package shell_rom_pkg;

	// ====================
	// address and data widths
	// ====================
	typedef logic [12:0] dl_addr_t;
	typedef logic [11:0] word_addr_t;
	// low byte holds the even address
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [11:0] cpu_addr_t;
	typedef logic [10:0] snd_addr_t;

	// word part of the CPU byte addresses
	typedef logic [10:0] cpu_word_t;
	typedef logic [9:0] snd_word_t;

	// ====================
	// region layout
	// ====================
	// sound ROM starts at image byte 0x1000
	localparam word_addr_t SND_WORD_BASE = 12'd2048;
	localparam int STORE_WORDS = 3072;
	// cycles from a taken request to its ack
	localparam int STORE_LATENCY = 2;

	typedef enum logic [1:0] {
		wait_image,
		loading,
		running
	} boot_state_t;

endpackage

`default_nettype wire
